// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int xlen = 64;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [2:0] {
        add    = 3'd0,
        sub    = 3'd1,
        and_op = 3'd2,
        or_op  = 3'd3,
        xor_op = 3'd4
    } alu_op_e;

    // Major opcodes of the kept subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_dword   = 3'b011;  // LD and SD
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

endpackage

`default_nettype wire

// ==== source/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        regfile  = 2'd0,
        from_mem = 2'd1,
        from_wb  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic                        valid;
        logic [isa_pkg::xlen-1:0]    pc;
        logic [31:0]                 instr;
    } if_id_t;

    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        logic             use_imm;
        logic             mem_read;
        logic             mem_write;
        logic             reg_write;
        logic             is_branch;
        logic             branch_ne;
        logic             is_jal;
    } ctrl_t;

    typedef struct packed {
        logic                        valid;
        logic [isa_pkg::xlen-1:0]    pc;
        ctrl_t                       ctrl;
        isa_pkg::reg_idx_t           rs1;
        isa_pkg::reg_idx_t           rs2;
        isa_pkg::reg_idx_t           rd;
        logic [isa_pkg::xlen-1:0]    rs1_data;
        logic [isa_pkg::xlen-1:0]    rs2_data;
        logic [isa_pkg::xlen-1:0]    imm;
    } id_ex_t;

    typedef struct packed {
        logic                        valid;
        logic [isa_pkg::xlen-1:0]    pc;
        logic                        mem_read;
        logic                        mem_write;
        logic                        reg_write;
        isa_pkg::reg_idx_t           rd;
        logic [isa_pkg::xlen-1:0]    alu_result;
        logic [isa_pkg::xlen-1:0]    store_data;
    } ex_me_t;

    typedef struct packed {
        logic                        valid;
        logic                        reg_write;
        isa_pkg::reg_idx_t           rd;
        logic [isa_pkg::xlen-1:0]    write_data;
    } me_wb_t;

    typedef struct packed {
        isa_pkg::reg_idx_t           rd;
        logic [isa_pkg::xlen-1:0]    data;
    } wb_obs_t;

    typedef struct packed {
        logic [isa_pkg::xlen-1:0]    addr;
        logic [isa_pkg::xlen-1:0]    data;
    } store_obs_t;

endpackage

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int imem_words = 64
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               run,
    input  wire logic                               stall,
    input  wire logic                               branch_taken,
    input  wire logic [isa_pkg::xlen-1:0]           branch_target,
    input  wire logic                               imem_we,
    input  wire logic [$clog2(imem_words)-1:0]      imem_addr,
    input  wire logic [31:0]                        imem_data,
    output pipe_pkg::if_id_t                        if_rec
);

    localparam int aw = $clog2(imem_words);

    logic [isa_pkg::xlen-1:0] pc;
    logic [isa_pkg::xlen-1:0] pc_next;
    logic [31:0]              imem [imem_words];

    // Load port, used while run is low
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall || !run) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign if_rec.valid = run;
    assign if_rec.pc    = pc;
    assign if_rec.instr = run ? imem[pc[aw+1:2]] : 32'd0;  // Idle slots carry a no-op

endmodule

`default_nettype wire

// ==== source/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire logic [31:0]                instr,
    output pipe_pkg::ctrl_t                 ctrl,
    output isa_pkg::reg_idx_t               rs1,
    output isa_pkg::reg_idx_t               rs2,
    output isa_pkg::reg_idx_t               rd,
    output logic [isa_pkg::xlen-1:0]        imm
);

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            isa_pkg::op_reg: begin
                ctrl.reg_write = 1'b1;
                if (f3 == isa_pkg::f3_add_sub && f7 == isa_pkg::f7_sub) begin
                    ctrl.alu_op = isa_pkg::sub;
                end else if (f7 != isa_pkg::f7_base) begin
                    ctrl.reg_write = 1'b0;
                end else begin
                    case (f3)
                        isa_pkg::f3_add_sub: ctrl.alu_op = isa_pkg::add;
                        isa_pkg::f3_xor:     ctrl.alu_op = isa_pkg::xor_op;
                        isa_pkg::f3_or:      ctrl.alu_op = isa_pkg::or_op;
                        isa_pkg::f3_and:     ctrl.alu_op = isa_pkg::and_op;
                        default:             ctrl.reg_write = 1'b0;
                    endcase
                end
            end
            isa_pkg::op_imm: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = (f3 == isa_pkg::f3_add_sub);  // ADDI only
                imm = {{52{instr[31]}}, instr[31:20]};
            end
            isa_pkg::op_load: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = (f3 == isa_pkg::f3_dword);
                ctrl.reg_write = (f3 == isa_pkg::f3_dword);
                imm = {{52{instr[31]}}, instr[31:20]};
            end
            isa_pkg::op_store: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = (f3 == isa_pkg::f3_dword);
                imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
            end
            isa_pkg::op_branch: begin
                ctrl.is_branch = (f3 == isa_pkg::f3_beq) || (f3 == isa_pkg::f3_bne);
                ctrl.branch_ne = (f3 == isa_pkg::f3_bne);
                imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            isa_pkg::op_jal: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: ;  // Unknown opcode acts as a no-op
        endcase
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire isa_pkg::reg_idx_t              rs1,
    input  wire isa_pkg::reg_idx_t              rs2,
    output logic [isa_pkg::xlen-1:0]            rs1_data,
    output logic [isa_pkg::xlen-1:0]            rs2_data,
    input  wire logic                           we,
    input  wire isa_pkg::reg_idx_t              wd_idx,
    input  wire logic [isa_pkg::xlen-1:0]       wd_data
);

    logic [isa_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_idx != '0) begin
            regs[wd_idx] <= wd_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rs1_data = (we && wd_idx != '0 && wd_idx == rs1) ? wd_data : regs[rs1];
    assign rs2_data = (we && wd_idx != '0 && wd_idx == rs2) ? wd_data : regs[rs2];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire pipe_pkg::id_ex_t               ex_rec,
    input  wire pipe_pkg::fwd_sel_e             fwd_a,
    input  wire pipe_pkg::fwd_sel_e             fwd_b,
    input  wire logic [isa_pkg::xlen-1:0]       mem_fwd_data,
    input  wire logic [isa_pkg::xlen-1:0]       wb_fwd_data,
    output logic [isa_pkg::xlen-1:0]            result,
    output logic [isa_pkg::xlen-1:0]            store_data,
    output logic                                branch_taken,
    output logic [isa_pkg::xlen-1:0]            branch_target
);

    logic [isa_pkg::xlen-1:0] op_a;
    logic [isa_pkg::xlen-1:0] reg_b;
    logic [isa_pkg::xlen-1:0] op_b;

    always_comb begin
        case (fwd_a)
            pipe_pkg::from_mem: op_a = mem_fwd_data;
            pipe_pkg::from_wb:  op_a = wb_fwd_data;
            default:            op_a = ex_rec.rs1_data;
        endcase
        case (fwd_b)
            pipe_pkg::from_mem: reg_b = mem_fwd_data;
            pipe_pkg::from_wb:  reg_b = wb_fwd_data;
            default:            reg_b = ex_rec.rs2_data;
        endcase
    end

    assign op_b       = ex_rec.ctrl.use_imm ? ex_rec.imm : reg_b;
    assign store_data = reg_b;

    always_comb begin
        if (ex_rec.ctrl.is_jal) begin
            result = ex_rec.pc + 64'd4;  // Link address
        end else begin
            case (ex_rec.ctrl.alu_op)
                isa_pkg::sub:    result = op_a - op_b;
                isa_pkg::and_op: result = op_a & op_b;
                isa_pkg::or_op:  result = op_a | op_b;
                isa_pkg::xor_op: result = op_a ^ op_b;
                default:         result = op_a + op_b;
            endcase
        end
    end

    assign branch_target = ex_rec.pc + ex_rec.imm;
    assign branch_taken  = ex_rec.valid && (ex_rec.ctrl.is_jal ||
                           (ex_rec.ctrl.is_branch && ((op_a == reg_b) != ex_rec.ctrl.branch_ne)));

endmodule

`default_nettype wire

// ==== source/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int dmem_words = 64
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire pipe_pkg::ex_me_t           me_rec,
    output logic [isa_pkg::xlen-1:0]        read_data,
    output logic                            store_valid,
    output pipe_pkg::store_obs_t            store_obs
);

    localparam int aw = $clog2(dmem_words);

    logic [isa_pkg::xlen-1:0] mem [dmem_words];
    logic [aw-1:0]            word_idx;

    assign word_idx = me_rec.alu_result[aw+2:3];  // 64-bit words

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (store_valid) begin
            mem[word_idx] <= me_rec.store_data;
        end
    end

    assign read_data      = mem[word_idx];
    assign store_valid    = me_rec.valid && me_rec.mem_write;
    assign store_obs.addr = me_rec.alu_result;
    assign store_obs.data = me_rec.store_data;

endmodule

`default_nettype wire

// ==== source/stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       hold,
    input  wire logic       clear,
    input  wire payload_t   d,
    output payload_t        q
);

    // Clear beats hold so a flush always squashes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire isa_pkg::reg_idx_t      id_rs1,
    input  wire isa_pkg::reg_idx_t      id_rs2,
    input  wire isa_pkg::reg_idx_t      ex_rs1,
    input  wire isa_pkg::reg_idx_t      ex_rs2,
    input  wire isa_pkg::reg_idx_t      ex_rd,
    input  wire isa_pkg::reg_idx_t      me_rd,
    input  wire logic                   me_reg_write,
    input  wire isa_pkg::reg_idx_t      wb_rd,
    input  wire logic                   wb_reg_write,
    input  wire logic                   ex_mem_read,
    input  wire logic                   branch_taken,
    output logic                        stall,
    output logic                        bubble,
    output logic                        flush,
    output pipe_pkg::fwd_sel_e          fwd_a,
    output pipe_pkg::fwd_sel_e          fwd_b
);

    logic load_use;

    // Memory stage is younger, so it wins
    function automatic pipe_pkg::fwd_sel_e pick_src(
        input isa_pkg::reg_idx_t rs
    );
        if (rs == '0) begin
            return pipe_pkg::regfile;
        end else if (me_reg_write && me_rd == rs) begin
            return pipe_pkg::from_mem;
        end else if (wb_reg_write && wb_rd == rs) begin
            return pipe_pkg::from_wb;
        end
        return pipe_pkg::regfile;
    endfunction

    always_comb begin
        fwd_a = pick_src(ex_rs1);
        fwd_b = pick_src(ex_rs2);
    end

    // The load in execute has no data until the memory stage
    assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign flush  = branch_taken;
    assign stall  = load_use && !flush;
    assign bubble = stall;

endmodule

`default_nettype wire

// ==== source/mini_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_pipeline #(
    parameter int imem_words = 64,
    parameter int dmem_words = 64
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           run,
    input  wire logic                           imem_we,
    input  wire logic [$clog2(imem_words)-1:0]  imem_addr,
    input  wire logic [31:0]                    imem_data,
    output logic                                wb_valid,
    output pipe_pkg::wb_obs_t                   wb_obs,
    output logic                                store_valid,
    output pipe_pkg::store_obs_t                store_obs
);

    pipe_pkg::if_id_t   if_rec, id_rec;
    pipe_pkg::id_ex_t   id_ex_d, ex_rec;
    pipe_pkg::ex_me_t   ex_me_d, me_rec;
    pipe_pkg::me_wb_t   me_wb_d, wb_rec;

    pipe_pkg::ctrl_t            dec_ctrl;
    isa_pkg::reg_idx_t          dec_rs1, dec_rs2, dec_rd;
    logic [isa_pkg::xlen-1:0]   dec_imm, rs1_data, rs2_data;
    logic [isa_pkg::xlen-1:0]   ex_result, ex_store_data, branch_target, read_data;
    logic                       branch_taken, stall, bubble, flush, rf_we;
    pipe_pkg::fwd_sel_e         fwd_a, fwd_b;

    fetch_unit #(.imem_words(imem_words)) i_fetch (
        .clk, .rst_n, .run, .stall, .branch_taken, .branch_target,
        .imem_we, .imem_addr, .imem_data, .if_rec
    );

    stage_reg #(.payload_t(pipe_pkg::if_id_t)) i_if_id (
        .clk, .rst_n, .hold(stall), .clear(flush), .d(if_rec), .q(id_rec)
    );

    decoder i_decoder (
        .instr(id_rec.instr), .ctrl(dec_ctrl),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm)
    );

    register_file i_regfile (
        .clk, .rst_n, .rs1(dec_rs1), .rs2(dec_rs2), .rs1_data, .rs2_data,
        .we(rf_we), .wd_idx(wb_rec.rd), .wd_data(wb_rec.write_data)
    );

    always_comb begin
        id_ex_d.valid    = id_rec.valid;
        id_ex_d.pc       = id_rec.pc;
        id_ex_d.ctrl     = id_rec.valid ? dec_ctrl : '0;  // Invalid slots never write
        id_ex_d.rs1      = dec_rs1;
        id_ex_d.rs2      = dec_rs2;
        id_ex_d.rd       = dec_rd;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = dec_imm;
    end

    stage_reg #(.payload_t(pipe_pkg::id_ex_t)) i_id_ex (
        .clk, .rst_n, .hold(1'b0), .clear(flush | bubble), .d(id_ex_d), .q(ex_rec)
    );

    alu i_alu (
        .ex_rec, .fwd_a, .fwd_b,
        .mem_fwd_data(me_wb_d.write_data), .wb_fwd_data(wb_rec.write_data),
        .result(ex_result), .store_data(ex_store_data), .branch_taken, .branch_target
    );

    always_comb begin
        ex_me_d.valid      = ex_rec.valid;
        ex_me_d.pc         = ex_rec.pc;
        ex_me_d.mem_read   = ex_rec.ctrl.mem_read;
        ex_me_d.mem_write  = ex_rec.ctrl.mem_write;
        ex_me_d.reg_write  = ex_rec.ctrl.reg_write;
        ex_me_d.rd         = ex_rec.rd;
        ex_me_d.alu_result = ex_result;
        ex_me_d.store_data = ex_store_data;
    end

    stage_reg #(.payload_t(pipe_pkg::ex_me_t)) i_ex_me (
        .clk, .rst_n, .hold(1'b0), .clear(1'b0), .d(ex_me_d), .q(me_rec)
    );

    data_memory #(.dmem_words(dmem_words)) i_dmem (
        .clk, .rst_n, .me_rec, .read_data, .store_valid, .store_obs
    );

    always_comb begin
        me_wb_d.valid      = me_rec.valid;
        me_wb_d.reg_write  = me_rec.reg_write;
        me_wb_d.rd         = me_rec.rd;
        me_wb_d.write_data = me_rec.mem_read ? read_data : me_rec.alu_result;
    end

    stage_reg #(.payload_t(pipe_pkg::me_wb_t)) i_me_wb (
        .clk, .rst_n, .hold(1'b0), .clear(1'b0), .d(me_wb_d), .q(wb_rec)
    );

    hazard_unit i_hazard (
        .id_rs1(dec_rs1), .id_rs2(dec_rs2), .ex_rs1(ex_rec.rs1), .ex_rs2(ex_rec.rs2),
        .ex_rd(ex_rec.rd), .me_rd(me_rec.rd), .me_reg_write(me_rec.valid & me_rec.reg_write),
        .wb_rd(wb_rec.rd), .wb_reg_write(rf_we),
        .ex_mem_read(ex_rec.ctrl.mem_read), .branch_taken,
        .stall, .bubble, .flush, .fwd_a, .fwd_b
    );

    assign rf_we       = wb_rec.valid && wb_rec.reg_write;
    assign wb_valid    = rf_we && wb_rec.rd != '0;  // x0 writes stay silent
    assign wb_obs.rd   = wb_rec.rd;
    assign wb_obs.data = wb_rec.write_data;

endmodule

`default_nettype wire

// ==== tests/mini_pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_pipeline_tb;

    localparam int stim_depth    = 256;
    localparam int event_timeout = 60;  // Cycles allowed per observed event
    localparam int idle_cycles   = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  run;
    logic                  imem_we;
    logic [5:0]            imem_addr;
    logic [31:0]           imem_data;
    logic                  wb_valid;
    pipe_pkg::wb_obs_t     wb_obs;
    logic                  store_valid;
    pipe_pkg::store_obs_t  store_obs;

    logic [63:0]           stim [stim_depth];

    pipe_pkg::wb_obs_t     wb_q [$];
    pipe_pkg::store_obs_t  st_q [$];

    int mismatch_count = 0;
    int timeout_count  = 0;
    int other_count    = 0;

    mini_pipeline #(
        .imem_words(64),
        .dmem_words(64)
    ) i_dut (
        .clk,
        .rst_n,
        .run,
        .imem_we,
        .imem_addr,
        .imem_data,
        .wb_valid,
        .wb_obs,
        .store_valid,
        .store_obs
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            mismatch_count++;
        end
    endtask

    // Blocks until the queue holds entry idx or the cycle budget runs out
    task automatic wait_for_event(input bit is_store, input int idx, output bit arrived);
        int cycles;
        cycles = 0;
        while ((is_store ? st_q.size() : wb_q.size()) <= idx && cycles < event_timeout) begin
            @(posedge clk);
            cycles++;
        end
        arrived = (is_store ? st_q.size() : wb_q.size()) > idx;
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst_n || !run) begin
            if (wb_valid !== 1'b0 || store_valid !== 1'b0) begin
                $display("Observation strobe active while the pipeline is idle at %0t", $time);
                other_count++;
            end
        end else begin
            if (wb_valid === 1'b1) begin
                wb_q.push_back(wb_obs);
            end
            if (store_valid === 1'b1) begin
                st_q.push_back(store_obs);
            end
            if ($isunknown(wb_valid) || $isunknown(store_valid)) begin
                $display("Observation strobe is unknown at %0t", $time);
                other_count++;
            end
        end
    end

    initial begin
        int n_prog;
        int n_wb;
        int n_st;
        int wb_base;
        int st_base;
        bit arrived;

        clk       = 1'b0;
        rst_n     = 1'b0;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        n_prog    = 0;
        n_wb      = 0;
        n_st      = 0;

        $readmemh("tests/pipeline_stim.txt", stim);
        if ($isunknown(stim[0]) || $isunknown(stim[1]) || $isunknown(stim[2])) begin
            $display("Stimulus file is missing or its header could not be read");
            other_count++;
        end else begin
            n_prog = stim[0][31:0];
            n_wb   = stim[1][31:0];
            n_st   = stim[2][31:0];
        end
        wb_base = 3 + n_prog;
        st_base = wb_base + 2 * n_wb;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Program load with the pipeline parked
        for (int i = 0; i < n_prog; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= i[5:0];
            imem_data <= stim[3 + i][31:0];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (3) @(posedge clk);
        run <= 1'b1;

        for (int i = 0; i < n_wb && timeout_count == 0; i++) begin
            wait_for_event(1'b0, i, arrived);
            if (!arrived) begin
                $display("Timeout: writeback %0d of %0d never arrived", i + 1, n_wb);
                timeout_count++;
            end else begin
                check_value("wb_obs.rd", wb_q[i].rd, stim[wb_base + 2 * i]);
                check_value("wb_obs.data", wb_q[i].data, stim[wb_base + 2 * i + 1]);
            end
        end

        for (int i = 0; i < n_st && timeout_count == 0; i++) begin
            wait_for_event(1'b1, i, arrived);
            if (!arrived) begin
                $display("Timeout: store %0d of %0d never arrived", i + 1, n_st);
                timeout_count++;
            end else begin
                check_value("store_obs.addr", st_q[i].addr, stim[st_base + 2 * i]);
                check_value("store_obs.data", st_q[i].data, stim[st_base + 2 * i + 1]);
            end
        end

        repeat (idle_cycles) @(posedge clk);
        if (wb_q.size() > n_wb) begin
            $display("Unexpected writebacks: %0d more than the %0d expected",
                     wb_q.size() - n_wb, n_wb);
            other_count++;
        end
        if (st_q.size() > n_st) begin
            $display("Unexpected stores: %0d more than the %0d expected",
                     st_q.size() - n_st, n_st);
            other_count++;
        end

        $display("mismatches=%0d timeouts=%0d other=%0d",
                 mismatch_count, timeout_count, other_count);
        if (mismatch_count == 0 && timeout_count == 0 && other_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/pipeline_stim.txt ====
// Header: program word count, writeback count, store count
// Then program words, writeback pairs (rd data) and store pairs (addr data)
1c d 2
// 0x00 addi x1 / addi x2 / sub x3 / add x4
00500093 00300113 401101b3 00118233
// 0x10 and x5 / or x6 / xor x7 / addi x0
002272b3 0020e333 003343b3 00908013
// 0x20 addi x8 / sd x7,16 / ld x9,16 / add x10
fff00413 00703823 01003483 00148533
// 0x30 sd x10,3(x1) / beq not taken / bne taken / squashed
00a0b1a3 00208463 00209663 00100593
// 0x40 squashed / beq taken / squashed / squashed
00103023 00520663 00200613 00300693
// 0x50 jal x14 / squashed / squashed / ld x16,8
00c0076f 00400793 00203023 00803803
// 0x60 add x17 / jal x0 self loop / nop / nop
00e808b3 0000006f 00000013 00000013
// Writebacks in retirement order
01 0000000000000005
02 0000000000000003
03 fffffffffffffffe
04 0000000000000003
05 0000000000000003
06 0000000000000007
07 fffffffffffffff9
08 ffffffffffffffff
09 fffffffffffffff9
0a fffffffffffffffe
0e 0000000000000054
10 fffffffffffffffe
11 0000000000000052
// Stores
10 fffffffffffffff9
08 fffffffffffffffe

// ==== mini_pipeline.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/register_file.sv
source/alu.sv
source/data_memory.sv
source/stage_reg.sv
source/hazard_unit.sv
source/mini_pipeline.sv
tests/mini_pipeline_tb.sv
